// ==== Makefile ====
TOP = tb_pad_control

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f verilog/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

# Verdict comes from the log, not the exit code of the binary
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "Run failed, see sim.log"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_pad_ref.svh ====
/*
 * Pad multiplexer reference model for the testbench
 *
 * Galois LFSR for stimulus, expected pad drive, configuration and
 * peripheral inputs, written from the pad map with literal pad numbers
 */

`ifndef TB_PAD_REF_SVH
`define TB_PAD_REF_SVH

// One Galois step, taps 32, 30, 26, 25
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
   return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
endfunction

////////////////////////////////////////////////////////////
// Pad side
////////////////////////////////////////////////////////////

// Peripheral mode drive of all pads as {oe, out}, pad 16 on the left
function automatic logic [33:0] periph_pins(
   input logic [3:0] spi_sdo, input logic [3:0] spi_oen, input logic [1:0] spi_csn,
   input logic spi_clk, input logic uart_tx, input logic sdio_clk,
   input logic sdio_cmd, input logic sdio_cmd_oen, input logic [3:0] sdio_data,
   input logic [3:0] sdio_data_oen, input logic i2c0_sda_out, input logic i2c0_sda_oe,
   input logic i2c0_scl_out, input logic i2c0_scl_oe);
   logic [16:0] out;
   logic [16:0] oe;
   // I2C0, SDIO data, cmd, clk, TX, RX, SCK, CSN, SPI data
   out = {i2c0_scl_out, i2c0_sda_out, sdio_data, sdio_cmd, sdio_clk, uart_tx, 1'b0,
          spi_clk, spi_csn, spi_sdo};
   // RX pad never drives
   oe  = {i2c0_scl_oe, i2c0_sda_oe, ~sdio_data_oen, ~sdio_cmd_oen, 1'b1, 1'b1, 1'b0,
          1'b1, 2'b11, ~spi_oen};
   return {oe, out};
endfunction

// I2C1 on pads 2, 7, 13 (SDA) and 3, 8, 14 (SCL), as {oe, out}
function automatic logic [33:0] alt_pins(input logic sda_out, input logic sda_oe,
                                         input logic scl_out, input logic scl_oe);
   logic [16:0] out;
   logic [16:0] oe;
   out = ({17{sda_out}} & 17'h02084) | ({17{scl_out}} & 17'h04108);
   oe  = ({17{sda_oe}} & 17'h02084) | ({17{scl_oe}} & 17'h04108);
   return {oe, out};
endfunction

// Selector codes 0 periph, 1 GPIO, 2 alternate, 3 none
function automatic logic [33:0] expected_drive(input logic [33:0] sel,
   input logic [33:0] periph, input logic [33:0] alt,
   input logic [16:0] gpio_out, input logic [16:0] gpio_dir);
   logic [16:0] out;
   logic [16:0] oe;
   for (int p = 0; p < 17; p++) begin
      case (sel[2*p +: 2])
         2'd0: begin
            out[p] = periph[p];
            oe[p]  = periph[17+p];
         end
         2'd1: begin
            out[p] = gpio_out[p];
            oe[p]  = gpio_dir[p];
         end
         2'd2: begin
            out[p] = alt[p];
            oe[p]  = alt[17+p];
         end
         default: begin
            out[p] = 1'b0;
            oe[p]  = 1'b0;
         end
      endcase
   end
   return {oe, out};
endfunction

// GPIO config only on GPIO pads
function automatic logic [101:0] expected_cfg(input logic [33:0] sel,
   input logic [101:0] pad_cfg, input logic [101:0] gpio_cfg);
   logic [101:0] cfg;
   for (int p = 0; p < 17; p++) begin
      cfg[6*p +: 6] = (sel[2*p +: 2] == 2'd1) ? gpio_cfg[6*p +: 6] : pad_cfg[6*p +: 6];
   end
   return cfg;
endfunction

////////////////////////////////////////////////////////////
// Peripheral side
////////////////////////////////////////////////////////////

// First listed pad in alternate mode wins, bus pulled up otherwise
function automatic logic alt_in(input logic [33:0] sel, input logic [16:0] pad_in,
                                input int a, input int b, input int c);
   if (sel[2*a +: 2] == 2'd2) return pad_in[a];
   if (sel[2*b +: 2] == 2'd2) return pad_in[b];
   if (sel[2*c +: 2] == 2'd2) return pad_in[c];
   return 1'b1;
endfunction

// {spi_sdi[3:0], uart_rx, sdio_cmd, sdio_data[3:0], sda_in[1:0], scl_in[1:0]}
function automatic logic [13:0] expected_inputs(input logic [33:0] sel,
                                                input logic [16:0] pad_in);
   logic [16:0] periph_in;
   for (int p = 0; p < 17; p++) begin
      periph_in[p] = (sel[2*p +: 2] == 2'd0) ? pad_in[p] : 1'b0;
   end
   // UART RX and I2C0 float high
   periph_in[7]  = (sel[15:14] == 2'd0) ? pad_in[7] : 1'b1;
   periph_in[15] = (sel[31:30] == 2'd0) ? pad_in[15] : 1'b1;
   periph_in[16] = (sel[33:32] == 2'd0) ? pad_in[16] : 1'b1;
   return {periph_in[3:0], periph_in[7], periph_in[10], periph_in[14:11],
           alt_in(sel, pad_in, 2, 7, 13), periph_in[15],
           alt_in(sel, pad_in, 3, 8, 14), periph_in[16]};
endfunction

function automatic logic [16:0] expected_gpio_in(input logic [33:0] sel,
                                                 input logic [16:0] pad_in);
   logic [16:0] gin;
   for (int p = 0; p < 17; p++) begin
      gin[p] = (sel[2*p +: 2] == 2'd1) ? pad_in[p] : 1'b0;
   end
   return gin;
endfunction

`endif

// ==== sim/tb_pad_control.sv ====
/*
 * Pad control testbench
 *
 * Random pad selectors and peripheral levels from an LFSR, applied on
 * the rising edge and checked against the reference model on the
 * falling edge, four tests of fixed length with a cycle limit
 */

`timescale 1ns/1ps
`default_nettype none

`include "tb_pad_ref.svh"

module tb_pad_control;

   import pad_ctrl_pkg::*;

   localparam int TEST_CYCLES = 200;
   localparam int N_TESTS     = 4;
   // Room for one extra test worth of cycles
   localparam int MAX_CYCLES  = (N_TESTS + 1) * TEST_CYCLES;

   logic clk;
   logic rst_n_i;

   // DUT ports
   pad_func_e [N_PADS-1:0]           pad_mux_i;
   logic [N_PADS-1:0][PAD_CFG_W-1:0] pad_cfg_i;
   logic [N_PADS-1:0][PAD_CFG_W-1:0] gpio_cfg_i;
   logic [N_PADS-1:0]                gpio_out_i;
   logic [N_PADS-1:0]                gpio_dir_i;
   logic [N_PADS-1:0]                gpio_in_o;
   logic [N_SPI_LINES-1:0]           spi_sdo_i;
   logic [N_SPI_LINES-1:0]           spi_oen_i;
   logic [1:0]                       spi_csn_i;
   logic                             spi_clk_i;
   logic [N_SPI_LINES-1:0]           spi_sdi_o;
   logic                             uart_tx_i;
   logic                             uart_rx_o;
   logic                             sdio_clk_i;
   logic                             sdio_cmd_i;
   logic                             sdio_cmd_oen_i;
   logic                             sdio_cmd_o;
   logic [N_SDIO_DATA-1:0]           sdio_data_i;
   logic [N_SDIO_DATA-1:0]           sdio_data_oen_i;
   logic [N_SDIO_DATA-1:0]           sdio_data_o;
   logic [1:0]                       i2c_sda_out_i;
   logic [1:0]                       i2c_sda_oe_i;
   logic [1:0]                       i2c_sda_in_o;
   logic [1:0]                       i2c_scl_out_i;
   logic [1:0]                       i2c_scl_oe_i;
   logic [1:0]                       i2c_scl_in_o;
   logic [N_PADS-1:0]                pad_in_i;
   logic [N_PADS-1:0]                pad_out_o;
   logic [N_PADS-1:0]                pad_oe_o;
   logic [N_PADS-1:0][PAD_CFG_W-1:0] pad_cfg_o;

   // Bookkeeping
   logic [31:0] lfsr        = 32'h012810cf;
   int          cycle_count = 0;
   int          check_count = 0;
   int          err_count   = 0;
   int          test_count  = 0;

   pad_control i_pad_control (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: no end of test after %0d clock cycles", MAX_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // Next n LFSR bits, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits[i] = lfsr[0];
         lfsr    = lfsr_step(lfsr);
      end
      return bits;
   endfunction

   task check_value(input string name, input logic [127:0] got, input logic [127:0] exp);
      check_count++;
      assert (got === exp) else begin
         $display("ERROR: time %0t %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
         err_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and checking
   ////////////////////////////////////////////////////////////

   // Selector mix depends on the test
   task drive_inputs(input int test_id);
      for (int p = 0; p < N_PADS; p++) begin
         case (test_id)
            1: pad_mux_i[p] <= FUNC_PERIPH;
            // Bias towards GPIO
            3: pad_mux_i[p] <= (take_bits(1) == 32'd1) ? FUNC_GPIO :
                               pad_func_e'(2'(take_bits(2)));
            // Alternate or released only
            4: pad_mux_i[p] <= (take_bits(1) == 32'd1) ? FUNC_ALT : FUNC_NONE;
            default: pad_mux_i[p] <= pad_func_e'(2'(take_bits(2)));
         endcase
         pad_cfg_i[p]  <= 6'(take_bits(6));
         gpio_cfg_i[p] <= 6'(take_bits(6));
      end
      gpio_out_i      <= 17'(take_bits(17));
      gpio_dir_i      <= 17'(take_bits(17));
      pad_in_i        <= 17'(take_bits(17));
      spi_sdo_i       <= 4'(take_bits(4));
      spi_oen_i       <= 4'(take_bits(4));
      spi_csn_i       <= 2'(take_bits(2));
      spi_clk_i       <= 1'(take_bits(1));
      uart_tx_i       <= 1'(take_bits(1));
      sdio_clk_i      <= 1'(take_bits(1));
      sdio_cmd_i      <= 1'(take_bits(1));
      sdio_cmd_oen_i  <= 1'(take_bits(1));
      sdio_data_i     <= 4'(take_bits(4));
      sdio_data_oen_i <= 4'(take_bits(4));
      i2c_sda_out_i   <= 2'(take_bits(2));
      i2c_sda_oe_i    <= 2'(take_bits(2));
      i2c_scl_out_i   <= 2'(take_bits(2));
      i2c_scl_oe_i    <= 2'(take_bits(2));
   endtask

   task check_outputs;
      logic [33:0] periph;
      logic [33:0] alt;
      logic [33:0] drive;
      logic [13:0] ins;
      periph = periph_pins(spi_sdo_i, spi_oen_i, spi_csn_i, spi_clk_i, uart_tx_i,
                           sdio_clk_i, sdio_cmd_i, sdio_cmd_oen_i, sdio_data_i,
                           sdio_data_oen_i, i2c_sda_out_i[0], i2c_sda_oe_i[0],
                           i2c_scl_out_i[0], i2c_scl_oe_i[0]);
      alt   = alt_pins(i2c_sda_out_i[1], i2c_sda_oe_i[1], i2c_scl_out_i[1], i2c_scl_oe_i[1]);
      drive = expected_drive(34'(pad_mux_i), periph, alt, gpio_out_i, gpio_dir_i);
      ins   = expected_inputs(34'(pad_mux_i), pad_in_i);
      // Pad frame side
      check_value("pad_out_o", 128'(pad_out_o), 128'(drive[16:0]));
      check_value("pad_oe_o", 128'(pad_oe_o), 128'(drive[33:17]));
      check_value("pad_cfg_o", 128'(pad_cfg_o),
                  128'(expected_cfg(34'(pad_mux_i), pad_cfg_i, gpio_cfg_i)));
      // Peripheral side
      check_value("spi_sdi_o", 128'(spi_sdi_o), 128'(ins[13:10]));
      check_value("uart_rx_o", 128'(uart_rx_o), 128'(ins[9]));
      check_value("sdio_cmd_o", 128'(sdio_cmd_o), 128'(ins[8]));
      check_value("sdio_data_o", 128'(sdio_data_o), 128'(ins[7:4]));
      check_value("i2c_sda_in_o", 128'(i2c_sda_in_o), 128'(ins[3:2]));
      check_value("i2c_scl_in_o", 128'(i2c_scl_in_o), 128'(ins[1:0]));
      check_value("gpio_in_o", 128'(gpio_in_o),
                  128'(expected_gpio_in(34'(pad_mux_i), pad_in_i)));
   endtask

   task run_test(input int test_id, input string title);
      int errs_at_start;
      errs_at_start = err_count;
      repeat (TEST_CYCLES) begin
         @(posedge clk);
         drive_inputs(test_id);
         // Combinational DUT, settled by mid cycle
         @(negedge clk);
         check_outputs();
      end
      test_count++;
      $display("Test %0d %s: %s, %0d errors", test_id, title,
               (err_count == errs_at_start) ? "ok" : "mismatches", err_count - errs_at_start);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n_i = 1'b0;
      for (int p = 0; p < N_PADS; p++) begin
         pad_mux_i[p] = FUNC_NONE;
      end
      pad_cfg_i       = '0;
      gpio_cfg_i      = '0;
      gpio_out_i      = '0;
      gpio_dir_i      = '0;
      pad_in_i        = '0;
      spi_sdo_i       = '0;
      spi_oen_i       = '1;
      spi_csn_i       = '1;
      spi_clk_i       = 1'b0;
      uart_tx_i       = 1'b1;
      sdio_clk_i      = 1'b0;
      sdio_cmd_i      = 1'b0;
      sdio_cmd_oen_i  = 1'b1;
      sdio_data_i     = '0;
      sdio_data_oen_i = '1;
      i2c_sda_out_i   = '0;
      i2c_sda_oe_i    = '0;
      i2c_scl_out_i   = '0;
      i2c_scl_oe_i    = '0;
      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;

      run_test(1, "peripheral mode outputs");
      run_test(2, "peripheral inputs");
      run_test(3, "GPIO mode");
      run_test(4, "I2C1 alternate routing");

      $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/pad_control.sv ====
/*
 * SoC pad control
 *
 * Joins the pad frame and the peripherals: the output mux drives
 * pad values, enables and configuration, the input router returns
 * pad inputs to SPI, UART, SDIO, I2C and GPIO
 */

`timescale 1ns/1ps
`default_nettype none

module pad_control (
   // Function selector and config registers
   input  pad_ctrl_pkg::pad_func_e [pad_ctrl_pkg::N_PADS-1:0] pad_mux_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] pad_cfg_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] gpio_cfg_i,

   // GPIO
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_out_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_dir_i,
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_in_o,

   // SPI master
   input  logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_sdo_i,
   input  logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_oen_i,
   input  logic [1:0]                                         spi_csn_i,
   input  logic                                               spi_clk_i,
   output logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_sdi_o,

   // UART
   input  logic                                               uart_tx_i,
   output logic                                               uart_rx_o,

   // SDIO
   input  logic                                               sdio_clk_i,
   input  logic                                               sdio_cmd_i,
   input  logic                                               sdio_cmd_oen_i,
   output logic                                               sdio_cmd_o,
   input  logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_i,
   input  logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_oen_i,
   output logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_o,

   // I2C0 on bit 0, I2C1 on bit 1
   input  logic [1:0]                                         i2c_sda_out_i,
   input  logic [1:0]                                         i2c_sda_oe_i,
   output logic [1:0]                                         i2c_sda_in_o,
   input  logic [1:0]                                         i2c_scl_out_i,
   input  logic [1:0]                                         i2c_scl_oe_i,
   output logic [1:0]                                         i2c_scl_in_o,

   // Pad frame
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_in_i,
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_out_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_oe_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] pad_cfg_o
);

   ////////////////////////////////////////////////////////////
   // Towards the pads
   ////////////////////////////////////////////////////////////

   pad_out_mux i_pad_out_mux (
      .pad_mux_i       (pad_mux_i),
      .gpio_out_i      (gpio_out_i),
      .gpio_dir_i      (gpio_dir_i),
      .gpio_cfg_i      (gpio_cfg_i),
      .pad_cfg_i       (pad_cfg_i),
      .spi_sdo_i       (spi_sdo_i),
      .spi_oen_i       (spi_oen_i),
      .spi_csn_i       (spi_csn_i),
      .spi_clk_i       (spi_clk_i),
      .uart_tx_i       (uart_tx_i),
      .sdio_clk_i      (sdio_clk_i),
      .sdio_cmd_i      (sdio_cmd_i),
      .sdio_cmd_oen_i  (sdio_cmd_oen_i),
      .sdio_data_i     (sdio_data_i),
      .sdio_data_oen_i (sdio_data_oen_i),
      .i2c_sda_out_i   (i2c_sda_out_i),
      .i2c_sda_oe_i    (i2c_sda_oe_i),
      .i2c_scl_out_i   (i2c_scl_out_i),
      .i2c_scl_oe_i    (i2c_scl_oe_i),
      .pad_out_o       (pad_out_o),
      .pad_oe_o        (pad_oe_o),
      .pad_cfg_o       (pad_cfg_o)
   );

   ////////////////////////////////////////////////////////////
   // Towards the peripherals
   ////////////////////////////////////////////////////////////

   pad_in_route i_pad_in_route (
      .pad_mux_i    (pad_mux_i),
      .pad_in_i     (pad_in_i),
      .spi_sdi_o    (spi_sdi_o),
      .uart_rx_o    (uart_rx_o),
      .sdio_cmd_o   (sdio_cmd_o),
      .sdio_data_o  (sdio_data_o),
      .i2c_sda_in_o (i2c_sda_in_o),
      .i2c_scl_in_o (i2c_scl_in_o),
      .gpio_in_o    (gpio_in_o)
   );

endmodule

`default_nettype wire

// ==== verilog/pad_ctrl_pkg.sv ====
/*
 * Pad multiplexer shared definitions
 *
 * Function selector encoding, pad numbering and widths for the
 * seventeen muxed pads, the I2C1 alternate pad lists in priority
 * order, and the idle levels seen by unrouted peripheral inputs
 */

`default_nettype none

package pad_ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Pad function selector
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      FUNC_PERIPH = 2'd0,  // Pad owned by its own peripheral
      FUNC_GPIO   = 2'd1,  // Pad owned by GPIO bit of same index
      FUNC_ALT    = 2'd2,  // I2C1, only on the listed pads
      FUNC_NONE   = 2'd3   // Idle pad
   } pad_func_e;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   // Muxed pads, also the GPIO width
   localparam int unsigned N_PADS      = 17;
   // Electrical config word per pad
   localparam int unsigned PAD_CFG_W   = 6;
   localparam int unsigned N_SPI_LINES = 4;
   localparam int unsigned N_SDIO_DATA = 4;

   ////////////////////////////////////////////////////////////
   // Pad indices
   ////////////////////////////////////////////////////////////

   // SPI master data lines
   localparam int unsigned PAD_SPIM_SDIO0 = 0;
   localparam int unsigned PAD_SPIM_SDIO1 = 1;
   localparam int unsigned PAD_SPIM_SDIO2 = 2;
   localparam int unsigned PAD_SPIM_SDIO3 = 3;
   // SPI chip selects and clock
   localparam int unsigned PAD_SPIM_CSN0  = 4;
   localparam int unsigned PAD_SPIM_CSN1  = 5;
   localparam int unsigned PAD_SPIM_SCK   = 6;
   // UART
   localparam int unsigned PAD_UART_RX    = 7;
   localparam int unsigned PAD_UART_TX    = 8;
   // SDIO
   localparam int unsigned PAD_SDIO_CLK   = 9;
   localparam int unsigned PAD_SDIO_CMD   = 10;
   localparam int unsigned PAD_SDIO_DATA0 = 11;
   localparam int unsigned PAD_SDIO_DATA1 = 12;
   localparam int unsigned PAD_SDIO_DATA2 = 13;
   localparam int unsigned PAD_SDIO_DATA3 = 14;
   // I2C0
   localparam int unsigned PAD_I2C0_SDA   = 15;
   localparam int unsigned PAD_I2C0_SCL   = 16;

   ////////////////////////////////////////////////////////////
   // I2C1 alternate pads, highest priority first
   ////////////////////////////////////////////////////////////

   localparam int unsigned N_I2C1_ALT = 3;

   localparam int unsigned I2C1_SDA_PADS [N_I2C1_ALT] =
      '{PAD_SPIM_SDIO2, PAD_UART_RX, PAD_SDIO_DATA2};
   localparam int unsigned I2C1_SCL_PADS [N_I2C1_ALT] =
      '{PAD_SPIM_SDIO3, PAD_UART_TX, PAD_SDIO_DATA3};

   // Input level when the pad is not routed to the peripheral
   localparam logic IDLE_PULLUP = 1'b1;  // I2C, UART RX
   localparam logic IDLE_LOW    = 1'b0;  // SPI, SDIO, GPIO

endpackage

`default_nettype wire

// ==== verilog/pad_in_route.sv ====
/*
 * Pad input router
 *
 * Hands each pad input to its peripheral while the pad is in
 * peripheral mode, otherwise the peripheral sees its idle level.
 * GPIO inputs are gated per pad and the I2C1 inputs come from the
 * first alternate pad of each list that is set to the alternate mode
 */

`timescale 1ns/1ps
`default_nettype none

module pad_in_route (
   // Function selector per pad
   input  pad_ctrl_pkg::pad_func_e [pad_ctrl_pkg::N_PADS-1:0] pad_mux_i,
   // Pad frame inputs
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_in_i,

   // Peripheral inputs
   output logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_sdi_o,
   output logic                                               uart_rx_o,
   output logic                                               sdio_cmd_o,
   output logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_o,
   // Bit 0 is I2C0 and bit 1 is I2C1
   output logic [1:0]                                         i2c_sda_in_o,
   output logic [1:0]                                         i2c_scl_in_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_in_o
);

   import pad_ctrl_pkg::*;

   // Resolved I2C1 inputs
   logic i2c1_sda_in;
   logic i2c1_scl_in;

   ////////////////////////////////////////////////////////////
   // Peripheral inputs, each gated by its own pad
   ////////////////////////////////////////////////////////////

   always_comb begin
      // SPI master data in
      spi_sdi_o[0] = (pad_mux_i[PAD_SPIM_SDIO0] == FUNC_PERIPH) ?
                     pad_in_i[PAD_SPIM_SDIO0] : IDLE_LOW;
      spi_sdi_o[1] = (pad_mux_i[PAD_SPIM_SDIO1] == FUNC_PERIPH) ?
                     pad_in_i[PAD_SPIM_SDIO1] : IDLE_LOW;
      spi_sdi_o[2] = (pad_mux_i[PAD_SPIM_SDIO2] == FUNC_PERIPH) ?
                     pad_in_i[PAD_SPIM_SDIO2] : IDLE_LOW;
      spi_sdi_o[3] = (pad_mux_i[PAD_SPIM_SDIO3] == FUNC_PERIPH) ?
                     pad_in_i[PAD_SPIM_SDIO3] : IDLE_LOW;

      // UART line idles high
      uart_rx_o    = (pad_mux_i[PAD_UART_RX] == FUNC_PERIPH) ?
                     pad_in_i[PAD_UART_RX] : IDLE_PULLUP;

      // SDIO command and data
      sdio_cmd_o     = (pad_mux_i[PAD_SDIO_CMD] == FUNC_PERIPH) ?
                       pad_in_i[PAD_SDIO_CMD] : IDLE_LOW;
      sdio_data_o[0] = (pad_mux_i[PAD_SDIO_DATA0] == FUNC_PERIPH) ?
                       pad_in_i[PAD_SDIO_DATA0] : IDLE_LOW;
      sdio_data_o[1] = (pad_mux_i[PAD_SDIO_DATA1] == FUNC_PERIPH) ?
                       pad_in_i[PAD_SDIO_DATA1] : IDLE_LOW;
      sdio_data_o[2] = (pad_mux_i[PAD_SDIO_DATA2] == FUNC_PERIPH) ?
                       pad_in_i[PAD_SDIO_DATA2] : IDLE_LOW;
      sdio_data_o[3] = (pad_mux_i[PAD_SDIO_DATA3] == FUNC_PERIPH) ?
                       pad_in_i[PAD_SDIO_DATA3] : IDLE_LOW;
   end

   // I2C0 bus released reads as pulled up
   assign i2c_sda_in_o[0] = (pad_mux_i[PAD_I2C0_SDA] == FUNC_PERIPH) ?
                            pad_in_i[PAD_I2C0_SDA] : IDLE_PULLUP;
   assign i2c_scl_in_o[0] = (pad_mux_i[PAD_I2C0_SCL] == FUNC_PERIPH) ?
                            pad_in_i[PAD_I2C0_SCL] : IDLE_PULLUP;

   ////////////////////////////////////////////////////////////
   // I2C1 priority search
   ////////////////////////////////////////////////////////////

   // Walk from lowest priority up so the first listed pad wins
   always_comb begin
      i2c1_sda_in = IDLE_PULLUP;
      i2c1_scl_in = IDLE_PULLUP;
      for (int k = N_I2C1_ALT - 1; k >= 0; k--) begin
         if (pad_mux_i[I2C1_SDA_PADS[k]] == FUNC_ALT) begin
            i2c1_sda_in = pad_in_i[I2C1_SDA_PADS[k]];
         end
         if (pad_mux_i[I2C1_SCL_PADS[k]] == FUNC_ALT) begin
            i2c1_scl_in = pad_in_i[I2C1_SCL_PADS[k]];
         end
      end
   end

   assign i2c_sda_in_o[1] = i2c1_sda_in;
   assign i2c_scl_in_o[1] = i2c1_scl_in;

   // GPIO bit p reads pad p only in GPIO mode
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         gpio_in_o[p] = (pad_mux_i[p] == FUNC_GPIO) ? pad_in_i[p] : IDLE_LOW;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pad_out_mux.sv ====
/*
 * Pad output multiplexer
 *
 * Selects, for every pad, the output value and output enable from
 * its peripheral, its GPIO bit or the I2C1 alternate function, and
 * picks the pad configuration word from GPIO or the pad registers
 */

`timescale 1ns/1ps
`default_nettype none

module pad_out_mux (
   // Function selector per pad
   input  pad_ctrl_pkg::pad_func_e [pad_ctrl_pkg::N_PADS-1:0] pad_mux_i,

   // GPIO
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_out_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]                    gpio_dir_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] gpio_cfg_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] pad_cfg_i,

   // SPI master
   input  logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_sdo_i,
   input  logic [pad_ctrl_pkg::N_SPI_LINES-1:0]               spi_oen_i,
   input  logic [1:0]                                         spi_csn_i,
   input  logic                                               spi_clk_i,

   // UART
   input  logic                                               uart_tx_i,

   // SDIO
   input  logic                                               sdio_clk_i,
   input  logic                                               sdio_cmd_i,
   input  logic                                               sdio_cmd_oen_i,
   input  logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_i,
   input  logic [pad_ctrl_pkg::N_SDIO_DATA-1:0]               sdio_data_oen_i,

   // I2C, bit 0 is I2C0 and bit 1 is I2C1
   input  logic [1:0]                                         i2c_sda_out_i,
   input  logic [1:0]                                         i2c_sda_oe_i,
   input  logic [1:0]                                         i2c_scl_out_i,
   input  logic [1:0]                                         i2c_scl_oe_i,

   // Pad frame
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_out_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0]                    pad_oe_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PAD_CFG_W-1:0] pad_cfg_o
);

   import pad_ctrl_pkg::*;

   // Per pad value and enable in peripheral mode
   logic [N_PADS-1:0] periph_out;
   logic [N_PADS-1:0] periph_oe;
   // Per pad value and enable in alternate mode
   logic [N_PADS-1:0] alt_out;
   logic [N_PADS-1:0] alt_oe;

   ////////////////////////////////////////////////////////////
   // Peripheral side gathered per pad
   ////////////////////////////////////////////////////////////

   always_comb begin
      // SPI data, enable is active low at the master
      periph_out[PAD_SPIM_SDIO0] = spi_sdo_i[0];
      periph_out[PAD_SPIM_SDIO1] = spi_sdo_i[1];
      periph_out[PAD_SPIM_SDIO2] = spi_sdo_i[2];
      periph_out[PAD_SPIM_SDIO3] = spi_sdo_i[3];
      periph_oe[PAD_SPIM_SDIO0]  = ~spi_oen_i[0];
      periph_oe[PAD_SPIM_SDIO1]  = ~spi_oen_i[1];
      periph_oe[PAD_SPIM_SDIO2]  = ~spi_oen_i[2];
      periph_oe[PAD_SPIM_SDIO3]  = ~spi_oen_i[3];

      // Always driven outputs
      periph_out[PAD_SPIM_CSN0]  = spi_csn_i[0];
      periph_out[PAD_SPIM_CSN1]  = spi_csn_i[1];
      periph_out[PAD_SPIM_SCK]   = spi_clk_i;
      periph_out[PAD_UART_TX]    = uart_tx_i;
      periph_out[PAD_SDIO_CLK]   = sdio_clk_i;
      periph_oe[PAD_SPIM_CSN0]   = 1'b1;
      periph_oe[PAD_SPIM_CSN1]   = 1'b1;
      periph_oe[PAD_SPIM_SCK]    = 1'b1;
      periph_oe[PAD_UART_TX]     = 1'b1;
      periph_oe[PAD_SDIO_CLK]    = 1'b1;

      // RX pad is input only
      periph_out[PAD_UART_RX]    = 1'b0;
      periph_oe[PAD_UART_RX]     = 1'b0;

      // SDIO command and data, active low enables
      periph_out[PAD_SDIO_CMD]   = sdio_cmd_i;
      periph_out[PAD_SDIO_DATA0] = sdio_data_i[0];
      periph_out[PAD_SDIO_DATA1] = sdio_data_i[1];
      periph_out[PAD_SDIO_DATA2] = sdio_data_i[2];
      periph_out[PAD_SDIO_DATA3] = sdio_data_i[3];
      periph_oe[PAD_SDIO_CMD]    = ~sdio_cmd_oen_i;
      periph_oe[PAD_SDIO_DATA0]  = ~sdio_data_oen_i[0];
      periph_oe[PAD_SDIO_DATA1]  = ~sdio_data_oen_i[1];
      periph_oe[PAD_SDIO_DATA2]  = ~sdio_data_oen_i[2];
      periph_oe[PAD_SDIO_DATA3]  = ~sdio_data_oen_i[3];

      // I2C0 open drain control passed straight through
      periph_out[PAD_I2C0_SDA]   = i2c_sda_out_i[0];
      periph_out[PAD_I2C0_SCL]   = i2c_scl_out_i[0];
      periph_oe[PAD_I2C0_SDA]    = i2c_sda_oe_i[0];
      periph_oe[PAD_I2C0_SCL]    = i2c_scl_oe_i[0];
   end

   // I2C1 lands on the listed pads, all others stay quiet
   always_comb begin
      alt_out = '0;
      alt_oe  = '0;
      for (int k = 0; k < N_I2C1_ALT; k++) begin
         alt_out[I2C1_SDA_PADS[k]] = i2c_sda_out_i[1];
         alt_oe[I2C1_SDA_PADS[k]]  = i2c_sda_oe_i[1];
         alt_out[I2C1_SCL_PADS[k]] = i2c_scl_out_i[1];
         alt_oe[I2C1_SCL_PADS[k]]  = i2c_scl_oe_i[1];
      end
   end

   ////////////////////////////////////////////////////////////
   // Four way function select per pad
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         // Pad registers own the config unless GPIO has the pad
         pad_cfg_o[p] = pad_cfg_i[p];
         case (pad_mux_i[p])
            FUNC_PERIPH: begin
               pad_out_o[p] = periph_out[p];
               pad_oe_o[p]  = periph_oe[p];
            end
            FUNC_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
               pad_cfg_o[p] = gpio_cfg_i[p];
            end
            FUNC_ALT: begin
               pad_out_o[p] = alt_out[p];
               pad_oe_o[p]  = alt_oe[p];
            end
            // FUNC_NONE, pad released
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
verilog/pad_ctrl_pkg.sv
verilog/pad_out_mux.sv
verilog/pad_in_route.sv
verilog/pad_control.sv
sim/tb_pad_control.sv
